/* Bender.yml */
package:
  name: ex_decoder

export_include_dirs:
  - src

sources:
  - src/ex_decode_pkg.sv
  - src/alu_mdu_decoder.sv
  - src/bmu_decoder.sv
  - src/system_decoder.sv
  - src/ex_ctrl_stage.sv
  - src/ex_decoder_top.sv
  - target: test
    files:
      - tb/tb_ex_decoder.sv

/* compile.f */
+incdir+src
src/ex_decode_pkg.sv
src/alu_mdu_decoder.sv
src/bmu_decoder.sv
src/system_decoder.sv
src/ex_ctrl_stage.sv
src/ex_decoder_top.sv
tb/tb_ex_decoder.sv

/* src/alu_mdu_decoder.sv */
`timescale 1ns/1ps
`include "ex_decode_consts.svh"

module alu_mdu_decoder (
    input  ex_decode_pkg::instr_word_u instr_i,
    output logic                       hit_o,
    output logic [`ALU_OP_W-1:0]       alu_op_o,
    output logic                       mdu_en_o,
    output logic [`MDU_OP_W-1:0]       mdu_op_o,
    output logic                       rs2_negate_o
);

    logic [`F3_W-1:0] f3;
    logic [`F7_W-1:0] shift_f7;

    assign f3       = instr_i.r.funct3;
    assign shift_f7 = instr_i.i.funct12[`F12_W-1:`F12_W-`F7_W]; // Above shamt

    // funct3 to op for the plain encodings
    function automatic logic [`ALU_OP_W-1:0] base_op(input logic [`F3_W-1:0] sel);
        case (sel)
            `F3_ADD:  return `ALU_ADD;
            `F3_SLL:  return `ALU_SLL;
            `F3_SLT:  return `ALU_SLT;
            `F3_SLTU: return `ALU_SLTU;
            `F3_XOR:  return `ALU_XOR;
            `F3_SR:   return `ALU_SRL;
            `F3_OR:   return `ALU_OR;
            default:  return `ALU_AND;
        endcase
    endfunction

    always_comb begin
        hit_o        = 1'b1;
        alu_op_o     = `ALU_ADD;
        mdu_en_o     = 1'b0;
        mdu_op_o     = '0;
        rs2_negate_o = 1'b0;
        case (instr_i.r.opcode)
            `OPC_LOAD, `OPC_STORE, `OPC_BRANCH,
            `OPC_AUIPC, `OPC_JAL, `OPC_JALR: alu_op_o = `ALU_ADD; // Address add
            `OPC_LUI: alu_op_o = `ALU_LUI;
            `OPC_OP_IMM: begin
                alu_op_o = base_op(f3);
                if (f3 == `F3_SLL) begin
                    hit_o = (shift_f7 == `F7_BASE);
                end else if (f3 == `F3_SR) begin
                    hit_o = (shift_f7 == `F7_BASE) || (shift_f7 == `F7_ALT);
                    alu_op_o = (shift_f7 == `F7_ALT) ? `ALU_SRA : `ALU_SRL;
                end
            end
            `OPC_OP: begin
                case (instr_i.r.funct7)
                    `F7_BASE: alu_op_o = base_op(f3);
                    `F7_ALT: begin
                        // SUB, ANDN and ORN go through the negated rs2 path
                        rs2_negate_o = (f3 == `F3_ADD) || (f3 == `F3_AND) || (f3 == `F3_OR);
                        case (f3)
                            `F3_ADD:         alu_op_o = `ALU_SUB;
                            `F3_SR:          alu_op_o = `ALU_SRA;
                            `F3_XOR:         alu_op_o = `ALU_XNOR;
                            `F3_OR, `F3_AND: alu_op_o = base_op(f3);
                            default:         hit_o = 1'b0;
                        endcase
                    end
                    `F7_MULDIV: begin
                        mdu_en_o = 1'b1;
                        mdu_op_o = f3; // MUL..REMU in funct3 order
                    end
                    default: hit_o = 1'b0;
                endcase
            end
            default: hit_o = 1'b0;
        endcase
    end

    mdu_needs_hit: assert final (!mdu_en_o || hit_o)
        else $error("MDU enabled on an encoding the decoder did not claim");

endmodule

/* src/bmu_decoder.sv */
`timescale 1ns/1ps
`include "ex_decode_consts.svh"

module bmu_decoder (
    input  ex_decode_pkg::instr_word_u instr_i,
    output logic                       hit_o,
    output logic [`BMU_OP_W-1:0]       bmu_op_o
);

    logic [`F3_W-1:0]  f3;
    logic [`F7_W-1:0]  f7;
    logic [`REG_W-1:0] rs2;

    assign f3  = instr_i.r.funct3;
    assign f7  = instr_i.r.funct7;
    assign rs2 = instr_i.r.rs2;

    always_comb begin
        hit_o    = 1'b1;
        bmu_op_o = `BMU_CLZ;
        if (instr_i.r.opcode == `OPC_OP_IMM && f3 == `F3_SLL) begin
            case (f7)
                `F7_ROT: begin
                    case (rs2) // Unary group
                        `RS2_CLZ:   bmu_op_o = `BMU_CLZ;
                        `RS2_CTZ:   bmu_op_o = `BMU_CTZ;
                        `RS2_CPOP:  bmu_op_o = `BMU_CPOP;
                        `RS2_SEXTB: bmu_op_o = `BMU_SEXTB;
                        `RS2_SEXTH: bmu_op_o = `BMU_SEXTH;
                        default:    hit_o = 1'b0;
                    endcase
                end
                `F7_BCLR: bmu_op_o = `BMU_BCLR;
                `F7_BINV: bmu_op_o = `BMU_BINV;
                `F7_BSET: bmu_op_o = `BMU_BSET;
                default:  hit_o = 1'b0; // SLLI stays with the ALU
            endcase
        end else if (instr_i.r.opcode == `OPC_OP_IMM && f3 == `F3_SR) begin
            case (f7)
                `F7_ROT:  bmu_op_o = `BMU_ROR; // RORI
                `F7_BCLR: bmu_op_o = `BMU_BEXT;
                `F7_BSET: begin
                    hit_o    = (rs2 == `RS2_ORCB);
                    bmu_op_o = `BMU_ORCB;
                end
                `F7_BINV: begin
                    hit_o    = (rs2 == `RS2_REV8);
                    bmu_op_o = `BMU_REV8;
                end
                default:  hit_o = 1'b0;
            endcase
        end else if (instr_i.r.opcode == `OPC_OP) begin
            case (f7)
                `F7_ZEXTH: begin
                    hit_o    = (f3 == `F3_ZEXTH) && (rs2 == '0);
                    bmu_op_o = `BMU_ZEXTH;
                end
                `F7_ROT: begin
                    hit_o    = (f3 == `F3_SLL) || (f3 == `F3_SR);
                    bmu_op_o = (f3 == `F3_SR) ? `BMU_ROR : `BMU_ROL;
                end
                `F7_BCLR: begin
                    hit_o    = (f3 == `F3_SLL) || (f3 == `F3_SR);
                    bmu_op_o = (f3 == `F3_SR) ? `BMU_BEXT : `BMU_BCLR;
                end
                `F7_BINV: begin
                    hit_o    = (f3 == `F3_SLL);
                    bmu_op_o = `BMU_BINV;
                end
                `F7_BSET: begin
                    hit_o    = (f3 == `F3_SLL);
                    bmu_op_o = `BMU_BSET;
                end
                `F7_MINMAX: begin
                    case (f3)
                        `F3_MIN:  bmu_op_o = `BMU_MIN;
                        `F3_MINU: bmu_op_o = `BMU_MINU;
                        `F3_MAXU: bmu_op_o = `BMU_MAXU;
                        `F3_MAX:  bmu_op_o = `BMU_MAX;
                        default:  hit_o = 1'b0;
                    endcase
                end
                default: hit_o = 1'b0;
            endcase
        end else begin
            hit_o = 1'b0;
        end
    end

endmodule

/* src/ex_ctrl_stage.sv */
`timescale 1ns/1ps
`include "ex_decode_consts.svh"

module ex_ctrl_stage (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 valid_i,
    input  logic                 stall_i,
    input  logic                 alu_hit_i,
    input  logic [`ALU_OP_W-1:0] alu_op_i,
    input  logic                 mdu_en_i,
    input  logic [`MDU_OP_W-1:0] mdu_op_i,
    input  logic                 rs2_negate_i,
    input  logic                 bmu_hit_i,
    input  logic [`BMU_OP_W-1:0] bmu_op_i,
    input  logic                 sys_hit_i,
    input  logic                 csr_en_i,
    input  logic [1:0]           csr_op_i,
    input  logic                 csr_imm_sel_i,
    input  logic [1:0]           privjump_i,
    output logic [1:0]           chip_sel_o,
    output logic [`ALU_OP_W-1:0] alu_op_o,
    output logic                 mdu_en_o,
    output logic [`MDU_OP_W-1:0] mdu_op_o,
    output logic [`BMU_OP_W-1:0] bmu_op_o,
    output logic                 csr_en_o,
    output logic [1:0]           csr_op_o,
    output logic                 csr_imm_sel_o,
    output logic [1:0]           privjump_o,
    output logic                 rs2_negate_o,
    output logic                 illegal_o,
    output logic                 valid_o
);

    logic       alu_sel;
    logic       bmu_sel;
    logic       sys_sel;
    logic       illegal;
    logic [1:0] cs_next;

    // Only a valid instruction selects a unit
    assign alu_sel = valid_i && alu_hit_i;
    assign bmu_sel = valid_i && bmu_hit_i;
    assign sys_sel = valid_i && sys_hit_i;
    assign illegal = valid_i && !(alu_hit_i || bmu_hit_i || sys_hit_i);

    always_comb begin
        cs_next = `CS_ALU; // Also for WFI and privileged jumps
        if (bmu_sel) begin
            cs_next = `CS_BMU;
        end else if (alu_sel && mdu_en_i) begin
            cs_next = `CS_MDU;
        end else if (sys_sel && csr_en_i) begin
            cs_next = `CS_CSR;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o       <= 1'b0;
            illegal_o     <= 1'b0;
            chip_sel_o    <= `CS_ALU;
            alu_op_o      <= '0;
            mdu_en_o      <= 1'b0;
            mdu_op_o      <= '0;
            rs2_negate_o  <= 1'b0;
            bmu_op_o      <= '0;
            csr_en_o      <= 1'b0;
            csr_op_o      <= '0;
            csr_imm_sel_o <= 1'b0;
            privjump_o    <= `PJ_NONE;
        end else if (!stall_i) begin
            valid_o       <= valid_i;
            illegal_o     <= illegal;
            chip_sel_o    <= cs_next;
            alu_op_o      <= alu_sel ? alu_op_i : '0;
            mdu_en_o      <= alu_sel && mdu_en_i;
            mdu_op_o      <= (alu_sel && mdu_en_i) ? mdu_op_i : '0;
            rs2_negate_o  <= alu_sel && rs2_negate_i;
            bmu_op_o      <= bmu_sel ? bmu_op_i : '0;
            csr_en_o      <= sys_sel && csr_en_i;
            csr_op_o      <= sys_sel ? csr_op_i : '0;
            csr_imm_sel_o <= sys_sel && csr_imm_sel_i;
            privjump_o    <= sys_sel ? privjump_i : `PJ_NONE;
        end
    end

    // Decoders own disjoint encoding spaces
    hits_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        valid_i |-> $onehot0({alu_hit_i, bmu_hit_i, sys_hit_i}))
        else $error("Several decoders claimed one instruction");

    valid_low_after_reset: assert property (@(posedge clk_i) reset_i |=> !valid_o)
        else $error("valid_o high in the cycle after reset");

endmodule

/* src/ex_decode_consts.svh */
`ifndef EX_DECODE_CONSTS_SVH
`define EX_DECODE_CONSTS_SVH

// Field widths
`define INSTR_W     30
`define OPC_W       5
`define REG_W       5
`define F3_W        3
`define F7_W        7
`define F12_W       12
`define ALU_OP_W    4
`define BMU_OP_W    5
`define MDU_OP_W    3

// Major opcodes, instr[6:2]
`define OPC_LOAD    5'b00000
`define OPC_STORE   5'b01000
`define OPC_BRANCH  5'b11000
`define OPC_JALR    5'b11001
`define OPC_JAL     5'b11011
`define OPC_AUIPC   5'b00101
`define OPC_LUI     5'b01101
`define OPC_OP_IMM  5'b00100
`define OPC_OP      5'b01100
`define OPC_SYSTEM  5'b11100

// funct3, shared by the base ops and their Zbb/Zbs relatives
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_MIN      3'b100
`define F3_MINU     3'b101
`define F3_MAX      3'b110
`define F3_MAXU     3'b111
`define F3_ZEXTH    3'b100
`define F3_PRIV     3'b000
`define F3_CSR_RSV  3'b100

// funct7
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000
`define F7_MULDIV   7'b0000001
`define F7_ZEXTH    7'b0000100
`define F7_ROT      7'b0110000
`define F7_BCLR     7'b0100100
`define F7_BINV     7'b0110100
`define F7_BSET     7'b0010100
`define F7_MINMAX   7'b0000101

// rs2 field as a sub-opcode for the unary group
`define RS2_CLZ     5'b00000
`define RS2_CTZ     5'b00001
`define RS2_CPOP    5'b00010
`define RS2_ORCB    5'b00111
`define RS2_SEXTB   5'b00100
`define RS2_SEXTH   5'b00101
`define RS2_REV8    5'b11000

// funct12 of the privileged group
`define F12_ECALL   12'h000
`define F12_EBREAK  12'h001
`define F12_MRET    12'h302
`define F12_WFI     12'h105

// ALU ops
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLL     4'd3
`define ALU_SLT     4'd4
`define ALU_SLTU    4'd5
`define ALU_XOR     4'd6
`define ALU_SRL     4'd7
`define ALU_SRA     4'd8
`define ALU_OR      4'd9
`define ALU_AND     4'd10
`define ALU_XNOR    4'd11
`define ALU_LUI     4'd12

// Chip select, privileged jump, CSR op
`define CS_ALU      2'd0
`define CS_MDU      2'd1
`define CS_BMU      2'd2
`define CS_CSR      2'd3
`define PJ_NONE     2'd0
`define PJ_MRET     2'd1
`define PJ_ECALL    2'd2
`define PJ_EBREAK   2'd3
`define CSR_RW      2'd1
`define CSR_RS      2'd2
`define CSR_RC      2'd3

// BMU ops
`define BMU_CLZ     5'd0
`define BMU_CTZ     5'd1
`define BMU_CPOP    5'd2
`define BMU_ORCB    5'd3
`define BMU_REV8    5'd4
`define BMU_ZEXTH   5'd5
`define BMU_SEXTB   5'd6
`define BMU_SEXTH   5'd7
`define BMU_ROL     5'd8
`define BMU_ROR     5'd9
`define BMU_MAX     5'd10
`define BMU_BCLR    5'd11
`define BMU_BEXT    5'd12
`define BMU_BINV    5'd13
`define BMU_BSET    5'd14
`define BMU_MAXU    5'd15
`define BMU_MIN     5'd16
`define BMU_MINU    5'd17

`endif

/* src/ex_decode_pkg.sv */
`include "ex_decode_consts.svh"

package ex_decode_pkg;

    // Register-register view
    typedef struct packed {
        logic [`F7_W-1:0]  funct7;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rs1;
        logic [`F3_W-1:0]  funct3;
        logic [`REG_W-1:0] rd;
        logic [`OPC_W-1:0] opcode;
    } r_fields_t;

    // Immediate view, funct12 overlays funct7 and rs2
    typedef struct packed {
        logic [`F12_W-1:0] funct12;
        logic [`REG_W-1:0] rs1;
        logic [`F3_W-1:0]  funct3;
        logic [`REG_W-1:0] rd;
        logic [`OPC_W-1:0] opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_word_u;

endpackage

/* src/ex_decoder_top.sv */
`timescale 1ns/1ps
`include "ex_decode_consts.svh"

module ex_decoder_top (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic [`INSTR_W-1:0]  instr_i,
    input  logic                 valid_i,
    input  logic                 stall_i,
    output logic [1:0]           chip_sel_o,
    output logic [`ALU_OP_W-1:0] alu_op_o,
    output logic                 mdu_en_o,
    output logic [`MDU_OP_W-1:0] mdu_op_o,
    output logic [`BMU_OP_W-1:0] bmu_op_o,
    output logic                 csr_en_o,
    output logic [1:0]           csr_op_o,
    output logic                 csr_imm_sel_o,
    output logic [1:0]           privjump_o,
    output logic                 rs2_negate_o,
    output logic                 illegal_o,
    output logic                 valid_o
);

    logic                 alu_hit;
    logic [`ALU_OP_W-1:0] alu_op;
    logic                 mdu_en;
    logic [`MDU_OP_W-1:0] mdu_op;
    logic                 rs2_negate;
    logic                 bmu_hit;
    logic [`BMU_OP_W-1:0] bmu_op;
    logic                 sys_hit;
    logic                 csr_en;
    logic [1:0]           csr_op;
    logic                 csr_imm_sel;
    logic [1:0]           privjump;

    alu_mdu_decoder u_alu_mdu (
        .instr_i      (instr_i),
        .hit_o        (alu_hit),
        .alu_op_o     (alu_op),
        .mdu_en_o     (mdu_en),
        .mdu_op_o     (mdu_op),
        .rs2_negate_o (rs2_negate)
    );

    bmu_decoder u_bmu (
        .instr_i  (instr_i),
        .hit_o    (bmu_hit),
        .bmu_op_o (bmu_op)
    );

    system_decoder u_system (
        .instr_i       (instr_i),
        .hit_o         (sys_hit),
        .csr_en_o      (csr_en),
        .csr_op_o      (csr_op),
        .csr_imm_sel_o (csr_imm_sel),
        .privjump_o    (privjump)
    );

    ex_ctrl_stage u_stage (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .valid_i       (valid_i),
        .stall_i       (stall_i),
        .alu_hit_i     (alu_hit),
        .alu_op_i      (alu_op),
        .mdu_en_i      (mdu_en),
        .mdu_op_i      (mdu_op),
        .rs2_negate_i  (rs2_negate),
        .bmu_hit_i     (bmu_hit),
        .bmu_op_i      (bmu_op),
        .sys_hit_i     (sys_hit),
        .csr_en_i      (csr_en),
        .csr_op_i      (csr_op),
        .csr_imm_sel_i (csr_imm_sel),
        .privjump_i    (privjump),
        .chip_sel_o    (chip_sel_o),
        .alu_op_o      (alu_op_o),
        .mdu_en_o      (mdu_en_o),
        .mdu_op_o      (mdu_op_o),
        .bmu_op_o      (bmu_op_o),
        .csr_en_o      (csr_en_o),
        .csr_op_o      (csr_op_o),
        .csr_imm_sel_o (csr_imm_sel_o),
        .privjump_o    (privjump_o),
        .rs2_negate_o  (rs2_negate_o),
        .illegal_o     (illegal_o),
        .valid_o       (valid_o)
    );

endmodule

/* src/system_decoder.sv */
`timescale 1ns/1ps
`include "ex_decode_consts.svh"

module system_decoder (
    input  ex_decode_pkg::instr_word_u instr_i,
    output logic                       hit_o,
    output logic                       csr_en_o,
    output logic [1:0]                 csr_op_o,
    output logic                       csr_imm_sel_o,
    output logic [1:0]                 privjump_o
);

    logic [`F3_W-1:0] f3;

    assign f3 = instr_i.i.funct3;

    always_comb begin
        hit_o         = 1'b0;
        csr_en_o      = 1'b0;
        csr_op_o      = '0;
        csr_imm_sel_o = 1'b0;
        privjump_o    = `PJ_NONE;
        if (instr_i.i.opcode == `OPC_SYSTEM) begin
            if (f3 != `F3_PRIV && f3 != `F3_CSR_RSV) begin
                hit_o         = 1'b1;
                csr_en_o      = 1'b1;
                csr_op_o      = f3[1:0];
                csr_imm_sel_o = f3[2]; // uimm in rs1 slot
            end else if (f3 == `F3_PRIV && instr_i.i.rd == '0 && instr_i.i.rs1 == '0) begin
                hit_o = 1'b1;
                case (instr_i.i.funct12)
                    `F12_ECALL:  privjump_o = `PJ_ECALL;
                    `F12_EBREAK: privjump_o = `PJ_EBREAK;
                    `F12_MRET:   privjump_o = `PJ_MRET;
                    `F12_WFI:    privjump_o = `PJ_NONE; // Runs as a NOP
                    default:     hit_o = 1'b0;
                endcase
            end
        end
    end

endmodule

/* tb/tb_ex_decoder.sv */
`timescale 1ns/1ps
`include "ex_decode_consts.svh"

module tb_ex_decoder;

    typedef struct packed {
        logic [1:0]           cs;
        logic [`ALU_OP_W-1:0] alu;
        logic                 mdu_en;
        logic [`MDU_OP_W-1:0] mdu_op;
        logic [`BMU_OP_W-1:0] bmu;
        logic                 csr_en;
        logic [1:0]           csr_op;
        logic                 csr_imm;
        logic [1:0]           pj;
        logic                 neg;
        logic                 ill;
        logic                 vld;
    } ctrl_t;

    typedef struct packed {
        logic [`INSTR_W-1:0] instr;
        logic                stall;
        ctrl_t               exp;
    } entry_t;

    logic                 clk;
    logic                 reset;
    logic [`INSTR_W-1:0]  instr;
    logic                 valid;
    logic                 stall;
    logic [1:0]           chip_sel;
    logic [`ALU_OP_W-1:0] alu_op;
    logic                 mdu_en;
    logic [`MDU_OP_W-1:0] mdu_op;
    logic [`BMU_OP_W-1:0] bmu_op;
    logic                 csr_en;
    logic [1:0]           csr_op;
    logic                 csr_imm_sel;
    logic [1:0]           privjump;
    logic                 rs2_negate;
    logic                 illegal;
    logic                 valid_out;

    entry_t              stim_q[$];
    ctrl_t               model;      // What the outputs should show now
    int                  pend_idx;
    logic [`INSTR_W-1:0] pend_instr;
    int                  errors;
    int                  tests_run;
    int                  tests_failed;
    integer              seed;
    logic                table_ready;

    ex_decoder_top dut (
        .clk_i         (clk),
        .reset_i       (reset),
        .instr_i       (instr),
        .valid_i       (valid),
        .stall_i       (stall),
        .chip_sel_o    (chip_sel),
        .alu_op_o      (alu_op),
        .mdu_en_o      (mdu_en),
        .mdu_op_o      (mdu_op),
        .bmu_op_o      (bmu_op),
        .csr_en_o      (csr_en),
        .csr_op_o      (csr_op),
        .csr_imm_sel_o (csr_imm_sel),
        .privjump_o    (privjump),
        .rs2_negate_o  (rs2_negate),
        .illegal_o     (illegal),
        .valid_o       (valid_out)
    );

    always #20 clk = ~clk;

    // rs1 = x2, rd = x1
    function automatic logic [`INSTR_W-1:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                      input logic [2:0] f3, input logic [4:0] opc);
        return {f7, rs2, 5'd2, f3, 5'd1, opc};
    endfunction

    function automatic logic [`INSTR_W-1:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                      input logic [2:0] f3, input logic [4:0] rd,
                                                      input logic [4:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic ctrl_t alu_result(input logic [`ALU_OP_W-1:0] op, input logic neg);
        ctrl_t c;
        c = '0;
        c.vld = 1'b1;
        c.alu = op;
        c.neg = neg;
        return c;
    endfunction

    function automatic ctrl_t mdu_result(input logic [2:0] f3);
        ctrl_t c;
        c = '0;
        c.vld    = 1'b1;
        c.cs     = `CS_MDU;
        c.mdu_en = 1'b1;
        c.mdu_op = f3;
        return c;
    endfunction

    function automatic ctrl_t bmu_result(input logic [`BMU_OP_W-1:0] op);
        ctrl_t c;
        c = '0;
        c.vld = 1'b1;
        c.cs  = `CS_BMU;
        c.bmu = op;
        return c;
    endfunction

    function automatic ctrl_t csr_result(input logic [2:0] f3);
        ctrl_t c;
        c = '0;
        c.vld     = 1'b1;
        c.cs      = `CS_CSR;
        c.csr_en  = 1'b1;
        c.csr_op  = f3[1:0];
        c.csr_imm = f3[2];
        return c;
    endfunction

    function automatic ctrl_t jump_result(input logic [1:0] pj);
        ctrl_t c;
        c = '0;
        c.vld = 1'b1;
        c.pj  = pj;
        return c;
    endfunction

    function automatic ctrl_t illegal_result();
        ctrl_t c;
        c = '0;
        c.vld = 1'b1;
        c.ill = 1'b1;
        return c;
    endfunction

    task automatic add_row(input logic [`INSTR_W-1:0] ins, input ctrl_t e);
        entry_t r;
        r.instr = ins;
        r.stall = 1'b0;
        r.exp   = e;
        stim_q.push_back(r);
    endtask

    // Outputs must keep the previous result while this row is presented
    task automatic add_stalled_row(input logic [`INSTR_W-1:0] ins);
        entry_t r;
        r.instr = ins;
        r.stall = 1'b1;
        r.exp   = '0;
        stim_q.push_back(r);
    endtask

    task automatic build_table();
        add_row(encode_i(12'd5, 5'd2, `F3_ADD, 5'd1, `OPC_OP_IMM), alu_result(`ALU_ADD, 1'b0));
        add_row(encode_i(12'd8, 5'd2, 3'b010, 5'd1, `OPC_LOAD), alu_result(`ALU_ADD, 1'b0));
        add_row(encode_r(`F7_ALT, 5'd3, `F3_ADD, `OPC_OP), alu_result(`ALU_SUB, 1'b1));
        add_stalled_row(encode_r(`F7_ALT, 5'd3, `F3_XOR, `OPC_OP));
        add_stalled_row(encode_r(`F7_ALT, 5'd3, `F3_XOR, `OPC_OP));
        add_row(encode_r(`F7_ALT, 5'd3, `F3_XOR, `OPC_OP), alu_result(`ALU_XNOR, 1'b0));
        add_row(encode_r(`F7_ALT, 5'd4, `F3_SR, `OPC_OP_IMM), alu_result(`ALU_SRA, 1'b0));
        add_row(encode_r(`F7_ALT, 5'd3, `F3_AND, `OPC_OP), alu_result(`ALU_AND, 1'b1));
        add_row(encode_i(12'h123, 5'd4, 3'd5, 5'd1, `OPC_LUI), alu_result(`ALU_LUI, 1'b0));
        for (int k = 0; k < 8; k++) begin // MUL..REMU
            add_row(encode_r(`F7_MULDIV, 5'd3, k[2:0], `OPC_OP), mdu_result(k[2:0]));
        end
        add_row(encode_r(`F7_ROT, `RS2_CLZ, `F3_SLL, `OPC_OP_IMM), bmu_result(`BMU_CLZ));
        add_row(encode_r(`F7_ROT, `RS2_CTZ, `F3_SLL, `OPC_OP_IMM), bmu_result(`BMU_CTZ));
        add_row(encode_r(`F7_ROT, `RS2_CPOP, `F3_SLL, `OPC_OP_IMM), bmu_result(`BMU_CPOP));
        add_row(encode_r(`F7_ROT, `RS2_SEXTB, `F3_SLL, `OPC_OP_IMM), bmu_result(`BMU_SEXTB));
        add_row(encode_r(`F7_ROT, `RS2_SEXTH, `F3_SLL, `OPC_OP_IMM), bmu_result(`BMU_SEXTH));
        add_row(encode_r(`F7_BSET, `RS2_ORCB, `F3_SR, `OPC_OP_IMM), bmu_result(`BMU_ORCB));
        add_row(encode_r(`F7_BINV, `RS2_REV8, `F3_SR, `OPC_OP_IMM), bmu_result(`BMU_REV8));
        add_row(encode_r(`F7_ZEXTH, 5'd0, `F3_ZEXTH, `OPC_OP), bmu_result(`BMU_ZEXTH));
        add_row(encode_r(`F7_ROT, 5'd3, `F3_SLL, `OPC_OP), bmu_result(`BMU_ROL));
        add_row(encode_r(`F7_ROT, 5'd3, `F3_SR, `OPC_OP), bmu_result(`BMU_ROR));
        add_row(encode_r(`F7_ROT, 5'd3, `F3_SR, `OPC_OP_IMM), bmu_result(`BMU_ROR));
        add_row(encode_r(`F7_BCLR, 5'd3, `F3_SLL, `OPC_OP), bmu_result(`BMU_BCLR));
        add_row(encode_r(`F7_BCLR, 5'd3, `F3_SLL, `OPC_OP_IMM), bmu_result(`BMU_BCLR));
        add_row(encode_r(`F7_BCLR, 5'd3, `F3_SR, `OPC_OP), bmu_result(`BMU_BEXT));
        add_row(encode_r(`F7_BCLR, 5'd3, `F3_SR, `OPC_OP_IMM), bmu_result(`BMU_BEXT));
        add_row(encode_r(`F7_BINV, 5'd3, `F3_SLL, `OPC_OP), bmu_result(`BMU_BINV));
        add_row(encode_r(`F7_BINV, 5'd3, `F3_SLL, `OPC_OP_IMM), bmu_result(`BMU_BINV));
        add_row(encode_r(`F7_BSET, 5'd3, `F3_SLL, `OPC_OP), bmu_result(`BMU_BSET));
        add_row(encode_r(`F7_BSET, 5'd3, `F3_SLL, `OPC_OP_IMM), bmu_result(`BMU_BSET));
        add_row(encode_r(`F7_MINMAX, 5'd3, `F3_MAX, `OPC_OP), bmu_result(`BMU_MAX));
        add_row(encode_r(`F7_MINMAX, 5'd3, `F3_MAXU, `OPC_OP), bmu_result(`BMU_MAXU));
        add_row(encode_r(`F7_MINMAX, 5'd3, `F3_MIN, `OPC_OP), bmu_result(`BMU_MIN));
        add_row(encode_r(`F7_MINMAX, 5'd3, `F3_MINU, `OPC_OP), bmu_result(`BMU_MINU));
        for (int k = 1; k < 8; k++) begin // CSRRW..CSRRCI, 100 is reserved
            if (k != 4) begin
                add_row(encode_i(12'h300, 5'd5, k[2:0], 5'd1, `OPC_SYSTEM), csr_result(k[2:0]));
            end
        end
        add_stalled_row(encode_i(`F12_ECALL, 5'd0, `F3_PRIV, 5'd0, `OPC_SYSTEM));
        add_row(encode_i(`F12_ECALL, 5'd0, `F3_PRIV, 5'd0, `OPC_SYSTEM), jump_result(`PJ_ECALL));
        add_row(encode_i(`F12_EBREAK, 5'd0, `F3_PRIV, 5'd0, `OPC_SYSTEM), jump_result(`PJ_EBREAK));
        add_row(encode_i(`F12_MRET, 5'd0, `F3_PRIV, 5'd0, `OPC_SYSTEM), jump_result(`PJ_MRET));
        add_row(encode_i(`F12_WFI, 5'd0, `F3_PRIV, 5'd0, `OPC_SYSTEM), jump_result(`PJ_NONE));
        add_row(encode_r(7'b0010000, 5'd3, 3'b100, `OPC_OP), illegal_result()); // sh2add
        add_row(encode_r(`F7_BASE, 5'd3, `F3_ADD, 5'b00010), illegal_result()); // CUSTOM-0
        add_row(encode_i(`F12_ECALL, 5'd0, `F3_PRIV, 5'd1, `OPC_SYSTEM), illegal_result());
        add_row(encode_r(7'b1111111, 5'd3, `F3_ADD, `OPC_OP), illegal_result());
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("error: time %0t signal %s expected %0h actual %0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_outputs(input ctrl_t e);
        check_field("chip_sel_o", e.cs, chip_sel);
        check_field("alu_op_o", e.alu, alu_op);
        check_field("mdu_en_o", e.mdu_en, mdu_en);
        check_field("mdu_op_o", e.mdu_op, mdu_op);
        check_field("bmu_op_o", e.bmu, bmu_op);
        check_field("csr_en_o", e.csr_en, csr_en);
        check_field("csr_op_o", e.csr_op, csr_op);
        check_field("csr_imm_sel_o", e.csr_imm, csr_imm_sel);
        check_field("privjump_o", e.pj, privjump);
        check_field("rs2_negate_o", e.neg, rs2_negate);
        check_field("illegal_o", e.ill, illegal);
        check_field("valid_o", e.vld, valid_out);
    endtask

    // Drive one cycle, then check the result of the cycle before
    task automatic run_slot(input logic [`INSTR_W-1:0] ins, input logic vld, input logic stl,
                            input ctrl_t e, input int idx);
        int err_before;
        @(posedge clk);
        instr <= ins;
        valid <= vld;
        stall <= stl;
        @(negedge clk);
        err_before = errors;
        check_outputs(model);
        if (pend_idx >= 0) begin
            tests_run++;
            if (errors != err_before) begin
                tests_failed++;
            end
            $display("test %0d instr %h stall %0b: %s", pend_idx, pend_instr,
                     stim_q[pend_idx].stall, (errors == err_before) ? "passed" : "failed");
        end
        if (!stl) begin
            model = vld ? e : '0; // Idle result equals the reset state
        end
        pend_idx   = idx;
        pend_instr = ins;
    endtask

    initial begin
        wait (table_ready);
        #(stim_q.size() * 4 * 40);
        $display("Timeout: the decoder run did not complete in the allotted time");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        entry_t ent;
        int     gap;
        int     err_before;
        clk          = 1'b0;
        reset        = 1'b1;
        instr        = '0;
        valid        = 1'b0;
        stall        = 1'b0;
        model        = '0;
        pend_idx     = -1;
        pend_instr   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'hb55a;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        err_before = errors;
        check_field("valid_o", 0, valid_out);
        check_field("illegal_o", 0, illegal);
        check_field("mdu_en_o", 0, mdu_en);
        check_field("csr_en_o", 0, csr_en);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("reset state: %s", (errors == err_before) ? "passed" : "failed");

        for (int i = 0; i < stim_q.size(); i++) begin
            ent = stim_q[i];
            // Odd stalled rows also drop valid_i
            run_slot(ent.instr, !(ent.stall && i[0]), ent.stall, ent.exp, i);
            if (i % 8 == 7) begin
                gap = 1 + ({$random(seed)} % 3); // Idle cycles with junk on instr
                repeat (gap) run_slot($random(seed), 1'b0, 1'b0, '0, -1);
            end
        end
        run_slot('0, 1'b0, 1'b0, '0, -1);

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
